// File: run_sim.sh
#!/bin/sh
# Build the sound board simulation with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module snd_board_tb \
    -f snd_board.f -o snd_sim || exit 1
./obj_dir/snd_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// File: snd_board.f
+incdir+src
src/snd_pkg.sv
src/snd_bus_decode.sv
src/snd_frac_cen.sv
src/snd_adpcm_player.sv
src/snd_mixer.sv
src/snd_board.sv
verification/snd_board_checker.sv
verification/snd_board_assertions.sv
verification/snd_board_tb.sv

// File: src/snd_adpcm_player.sv
// ADPCM phrase player
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_adpcm_player (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen_pcm,
    input  snd_pkg::pcm_ctrl_t   pcm_ctrl,
    output logic                 busy,
    output logic                 pcm_cs,
    output snd_pkg::pcm_addr_t   pcm_addr,
    input  snd_pkg::cpu_data_t   pcm_data,
    input  logic                 pcm_ok,
    output snd_pkg::pcm_sample_t sound
);

    snd_pkg::adpcm_state_t state;
    snd_pkg::cpu_data_t    count;     // Data bytes still to fetch
    snd_pkg::cpu_data_t    data_byte;
    logic                  tick_pend; // Tick seen while fetching
    logic [3:0]            idx;
    logic [3:0]            nib;
    logic [3:0]            idx_next;
    logic [7:0]            step;
    logic [11:0]           delta;
    logic signed [11:0]    acc;
    snd_pkg::pcm_sample_t  sound_next;
    logic                  start;
    logic                  fetch_ok;
    logic                  decode_now;

    function automatic logic [7:0] step_of(input logic [3:0] i);
        case (i)
            4'd0:    step_of = 8'd1;
            4'd1:    step_of = 8'd2;
            4'd2:    step_of = 8'd3;
            4'd3:    step_of = 8'd4;
            4'd4:    step_of = 8'd6;
            4'd5:    step_of = 8'd8;
            4'd6:    step_of = 8'd11;
            4'd7:    step_of = 8'd16;
            4'd8:    step_of = 8'd22;
            4'd9:    step_of = 8'd32;
            4'd10:   step_of = 8'd45;
            4'd11:   step_of = 8'd64;
            4'd12:   step_of = 8'd90;
            4'd13:   step_of = 8'd128;
            4'd14:   step_of = 8'd181;
            default: step_of = 8'd255;
        endcase
    endfunction

    assign start      = pcm_ctrl.play_start && !pcm_ctrl.hold_rst;
    assign fetch_ok   = pcm_cs && pcm_ok && !pcm_ctrl.hold_rst && !pcm_ctrl.play_start;
    assign decode_now = (state == snd_pkg::st_decode_hi || state == snd_pkg::st_decode_lo)
                        && (cen_pcm || tick_pend) && !pcm_ctrl.hold_rst && !pcm_ctrl.play_start;
    assign busy       = state != snd_pkg::st_idle && !pcm_ctrl.hold_rst;

    // Nibble decode, high nibble first
    always_comb begin
        nib   = (state == snd_pkg::st_decode_hi) ? data_byte[7:4] : data_byte[3:0];
        step  = step_of(idx);
        delta = (12'(step) * 12'({nib[2:0], 1'b1})) >> 3;
        acc   = nib[3] ? 12'(sound) - $signed(delta) : 12'(sound) + $signed(delta);
        if (acc > 12'sd255) begin
            sound_next = 9'sd255;
        end else if (acc < -12'sd255) begin
            sound_next = -9'sd255;
        end else begin
            sound_next = acc[8:0];
        end
        if (nib[2:0] < 3'd4) begin
            idx_next = (idx == 4'd0) ? 4'd0 : idx - 4'd1;
        end else begin
            idx_next = (idx > 4'd13) ? 4'd15 : idx + 4'd2;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= snd_pkg::st_idle;
            pcm_cs    <= 1'b0;
            tick_pend <= 1'b0;
        end else if (pcm_ctrl.hold_rst) begin
            state     <= snd_pkg::st_idle; // Drops any pending fetch
            pcm_cs    <= 1'b0;
            tick_pend <= 1'b0;
        end else if (pcm_ctrl.play_start) begin
            state     <= snd_pkg::st_fetch_len;
            pcm_cs    <= 1'b0;  // Low for a cycle while the address reloads
            tick_pend <= 1'b0;
        end else begin
            case (state)
                snd_pkg::st_fetch_len, snd_pkg::st_fetch_data: begin
                    if (cen_pcm) begin
                        tick_pend <= 1'b1;
                    end
                    if (!pcm_cs) begin
                        pcm_cs <= 1'b1;
                    end else if (pcm_ok) begin
                        pcm_cs <= 1'b0;
                        if (state == snd_pkg::st_fetch_data) begin
                            state <= snd_pkg::st_decode_hi;
                        end else if (pcm_data == 8'd0) begin
                            state <= snd_pkg::st_idle; // Empty phrase
                        end else begin
                            state <= snd_pkg::st_fetch_data;
                        end
                    end
                end
                snd_pkg::st_decode_hi: begin
                    if (decode_now) begin
                        tick_pend <= 1'b0;
                        state     <= snd_pkg::st_decode_lo;
                    end
                end
                snd_pkg::st_decode_lo: begin
                    if (decode_now) begin
                        state <= (count == 8'd0) ? snd_pkg::st_idle : snd_pkg::st_fetch_data;
                    end
                end
                default: ;
            endcase
        end
    end

    // Address, length and data byte
    always_ff @(posedge clk) begin
        if (start) begin
            pcm_addr <= {pcm_ctrl.phrase, {(`PCM_AW-8){1'b0}}};
        end else if (fetch_ok) begin
            pcm_addr  <= pcm_addr + 1'b1;
            data_byte <= pcm_data;
            if (state == snd_pkg::st_fetch_len) begin
                count <= pcm_data;
            end else begin
                count <= count - 8'd1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sound <= '0;
            idx   <= 4'd0;
        end else if (pcm_ctrl.hold_rst || pcm_ctrl.play_start) begin
            sound <= '0;
            idx   <= 4'd0;
        end else if (decode_now) begin
            sound <= sound_next;
            idx   <= idx_next;
        end else if (state == snd_pkg::st_idle && cen_pcm) begin
            sound <= '0; // Last sample kept until the next tick
        end
    end

endmodule

// File: src/snd_board.sv
// Arcade sound board
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_board (
    input  logic                 clk,
    input  logic                 rst,
    input  snd_pkg::snd_bus_t    bus,
    input  logic                 snd_irq,
    input  snd_pkg::cpu_data_t   snd_latch,
    input  snd_pkg::cpu_data_t   rom_data,
    input  logic                 rom_ok,
    input  snd_pkg::cpu_data_t   fm_dout,
    input  snd_pkg::snd_sample_t fm_snd,
    output snd_pkg::cpu_data_t   cpu_din,
    output logic                 cpu_wait_n,
    output logic                 rom_cs,
    output logic [`SND_AW-2:0]   rom_addr,
    output logic                 ram_cs,
    output logic                 fm_cs,
    output logic                 int_n,
    output logic                 pcm_cs,
    output snd_pkg::pcm_addr_t   pcm_addr,
    input  snd_pkg::cpu_data_t   pcm_data,
    input  logic                 pcm_ok,
    output snd_pkg::snd_sample_t snd_left,
    output snd_pkg::snd_sample_t snd_right,
    output logic                 sample
);

    snd_pkg::pcm_ctrl_t   pcm_ctrl;
    snd_pkg::pcm_sample_t pcm_snd;
    logic                 busy;
    logic                 cen_pcm;

    assign cpu_wait_n = rom_ok; // CPU stalls until the ROM answers

    snd_bus_decode decode_i (
        .clk, .rst, .bus, .snd_irq, .snd_latch, .rom_data, .fm_dout, .busy,
        .cpu_din, .rom_cs, .rom_addr, .ram_cs, .fm_cs, .int_n, .pcm_ctrl
    );

    snd_frac_cen cen_i (
        .clk, .rst, .cen_pcm
    );

    snd_adpcm_player player_i (
        .clk, .rst, .cen_pcm, .pcm_ctrl, .busy,
        .pcm_cs, .pcm_addr, .pcm_data, .pcm_ok,
        .sound (pcm_snd)
    );

    snd_mixer mixer_i (
        .clk, .rst, .cen_pcm, .fm_snd, .pcm_snd,
        .snd_left, .snd_right, .sample
    );

endmodule

// File: src/snd_bus_decode.sv
// Sound CPU address decoder
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_bus_decode (
    input  logic               clk,
    input  logic               rst,
    input  snd_pkg::snd_bus_t  bus,
    input  logic               snd_irq,
    input  snd_pkg::cpu_data_t snd_latch,
    input  snd_pkg::cpu_data_t rom_data,
    input  snd_pkg::cpu_data_t fm_dout,
    input  logic               busy,
    output snd_pkg::cpu_data_t cpu_din,
    output logic               rom_cs,
    output logic [`SND_AW-2:0] rom_addr,
    output logic               ram_cs,
    output logic               fm_cs,
    output logic               int_n,
    output snd_pkg::pcm_ctrl_t pcm_ctrl
);

    logic       upper;
    logic [2:0] region;
    logic       play_cs;
    logic       platch_cs;
    logic       busy_cs;
    logic       prst_cs;
    logic       latch_cs;
    logic       irq_last;
    logic       irq_q;

    assign rom_addr = bus.addr[`SND_AW-2:0];
    assign region   = bus.addr[14:12];
    assign upper    = bus.mreq && bus.addr[`SND_AW-1]; // 8000h and up

    always_comb begin
        rom_cs    = bus.mreq && !bus.addr[`SND_AW-1] && bus.rd;
        ram_cs    = upper && region == `MAP_RAM;
        play_cs   = upper && region == `MAP_PLAY;
        platch_cs = upper && region == `MAP_PLATCH;
        busy_cs   = upper && region == `MAP_BUSY;
        prst_cs   = upper && region == `MAP_PRST;
        latch_cs  = upper && region == `MAP_LATCH;
        fm_cs     = upper && region == `MAP_FM;
    end

    // Read data back to the CPU
    always_comb begin
        if (rom_cs) begin
            cpu_din = rom_data;
        end else if (latch_cs) begin
            cpu_din = snd_latch;
        end else if (fm_cs) begin
            cpu_din = fm_dout;
        end else if (busy_cs) begin
            cpu_din = {7'd0, ~busy}; // Bit 0 high when the player is free
        end else begin
            cpu_din = 8'hff;          // RAM contents are outside the board
        end
    end

    // ADPCM control registers
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pcm_ctrl.phrase     <= 8'd0;
            pcm_ctrl.play_start <= 1'b0;
            pcm_ctrl.hold_rst   <= 1'b1;
        end else begin
            pcm_ctrl.play_start <= 1'b0;
            if (bus.wr) begin
                if (platch_cs) begin
                    pcm_ctrl.phrase <= bus.wdata;
                end
                if (play_cs) begin
                    pcm_ctrl.play_start <= ~bus.wdata[1]; // Start is active low
                end
                if (prst_cs) begin
                    pcm_ctrl.hold_rst <= ~bus.wdata[0];
                end
            end
        end
    end

    // Interrupt set by a rising edge of snd_irq, cleared by acknowledge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            irq_last <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            irq_last <= snd_irq;
            if (snd_irq && !irq_last) begin
                irq_q <= 1'b1;  // New edge wins over a late ack
            end else if (bus.irq_ack) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign int_n = ~irq_q;

endmodule

// File: src/snd_defs.svh
// Sound board parameters
`ifndef SND_DEFS_SVH
`define SND_DEFS_SVH

`define SND_AW 16   // CPU address bus
`define PCM_AW 17   // Sample ROM address bus
`define PCM_SW 9    // Signed ADPCM output
`define SND_OW 16   // Mixed output

`define CEN_N 2     // ADPCM enable is CEN_N/CEN_M of clk
`define CEN_M 75

`define GAIN_FM  16 // Mixer gains, sum is shifted right by 4
`define GAIN_PCM 96

// Region codes on address bits 14..12 of the upper half
`define MAP_RAM    3'd0
`define MAP_PLAY   3'd1
`define MAP_PLATCH 3'd2
`define MAP_BUSY   3'd3
`define MAP_PRST   3'd4
`define MAP_LATCH  3'd5
`define MAP_FM     3'd6
`endif

// File: src/snd_frac_cen.sv
// Fractional clock enable
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_frac_cen (
    input  logic clk,
    input  logic rst,
    output logic cen_pcm
);

    localparam int aw = $clog2(`CEN_M + `CEN_N);

    logic [aw-1:0] acc;
    logic [aw-1:0] acc_sum;

    assign acc_sum = acc + aw'(`CEN_N);

    // Pulse spacing is either floor or ceil of CEN_M/CEN_N
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc     <= '0;
            cen_pcm <= 1'b0;
        end else begin
            if (acc_sum >= aw'(`CEN_M)) begin
                acc     <= acc_sum - aw'(`CEN_M);
                cen_pcm <= 1'b1;
            end else begin
                acc     <= acc_sum;
                cen_pcm <= 1'b0;
            end
        end
    end

endmodule

// File: src/snd_mixer.sv
// FM and ADPCM mixer
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen_pcm,
    input  snd_pkg::snd_sample_t fm_snd,
    input  snd_pkg::pcm_sample_t pcm_snd,
    output snd_pkg::snd_sample_t snd_left,
    output snd_pkg::snd_sample_t snd_right,
    output logic                 sample
);

    localparam int mw = 24;

    logic signed [mw-1:0] fm_term;
    logic signed [mw-1:0] pcm_term;
    logic signed [mw-1:0] mix_shr;
    snd_pkg::snd_sample_t mix_sat;

    always_comb begin
        fm_term  = mw'(fm_snd * `GAIN_FM);
        pcm_term = mw'(pcm_snd * `GAIN_PCM);
        mix_shr  = (fm_term + pcm_term) >>> 4;
        if (mix_shr > mw'(32767)) begin
            mix_sat = 16'sh7fff;
        end else if (mix_shr < -mw'(32768)) begin
            mix_sat = 16'sh8000;
        end else begin
            mix_sat = mix_shr[`SND_OW-1:0];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd_left <= '0;
            sample   <= 1'b0;
        end else begin
            sample <= cen_pcm; // Marks the cycle the new value shows
            if (cen_pcm) begin
                snd_left <= mix_sat;
            end
        end
    end

    assign snd_right = snd_left; // Mono board

endmodule

// File: src/snd_pkg.sv
// Sound board types
`include "snd_defs.svh"

package snd_pkg;

    typedef logic [`SND_AW-1:0]        cpu_addr_t;
    typedef logic [7:0]                cpu_data_t;
    typedef logic [`PCM_AW-1:0]        pcm_addr_t;
    typedef logic signed [`PCM_SW-1:0] pcm_sample_t;
    typedef logic signed [`SND_OW-1:0] snd_sample_t;

    // CPU side of the board as driven by the sound CPU
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t wdata;
        logic      mreq;
        logic      rd;
        logic      wr;      // One-cycle strobe
        logic      irq_ack; // One-cycle pulse
    } snd_bus_t;

    typedef struct packed {
        cpu_data_t phrase;
        logic      play_start; // One-cycle pulse
        logic      hold_rst;   // Level that holds the player in idle
    } pcm_ctrl_t;

    typedef enum logic [2:0] {
        st_idle, st_fetch_len, st_fetch_data, st_decode_hi, st_decode_lo
    } adpcm_state_t;

endpackage

// File: verification/snd_board_assertions.sv
// Sound board protocol assertions
`timescale 1ns/1ps

module snd_board_assertions (
    input logic               clk,
    input logic               rst,
    input logic               pcm_cs,
    input logic               pcm_ok,
    input snd_pkg::pcm_addr_t pcm_addr,
    input snd_pkg::pcm_ctrl_t pcm_ctrl,
    input logic               busy,
    input logic               rom_cs,
    input logic               ram_cs,
    input logic               fm_cs
);

    // A pending sample ROM read keeps its address and select
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        pcm_cs && !pcm_ok && !pcm_ctrl.play_start && !pcm_ctrl.hold_rst |=> $stable(pcm_addr))
        else $error("pcm_addr changed while waiting for pcm_ok");

    a_cs_held: assert property (@(posedge clk) disable iff (rst)
        pcm_cs && !pcm_ok && !pcm_ctrl.play_start && !pcm_ctrl.hold_rst |=> pcm_cs)
        else $error("pcm_cs dropped before pcm_ok");

    // Holding the player in reset leaves it idle with no fetch
    a_hold_idle: assert property (@(posedge clk) disable iff (rst)
        pcm_ctrl.hold_rst |=> !busy && !pcm_cs)
        else $error("player still busy or fetching after being held in reset");

    a_one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, fm_cs}))
        else $error("more than one region select active");

endmodule

bind snd_board snd_board_assertions assert_i (
    .clk, .rst, .pcm_cs, .pcm_ok, .pcm_addr, .pcm_ctrl, .busy, .rom_cs, .ram_cs, .fm_cs
);

// File: verification/snd_board_checker.sv
// Sound board output checker
`timescale 1ns/1ps

module snd_board_checker (
    input logic                 clk,
    input logic                 sample,
    input snd_pkg::snd_sample_t snd_left,
    input snd_pkg::snd_sample_t snd_right
);

    int err_count = 0;
    int test_errs = 0;
    int tests     = 0;
    int failed    = 0;
    int pos       = 0;
    bit armed     = 1'b0;
    int exp_q[$];

    task automatic check_value(input string sig, input int exp, input int act);
        if (exp != act) begin
            $display("mismatch at %0t ns: %s expected %0d actual %0d", $time, sig, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_count++;
        test_errs++;
    endtask

    task automatic clear_stream();
        exp_q.delete();
        pos   = 0;
        armed = 1'b0;
    endtask

    task automatic push_expected(input int v);
        exp_q.push_back(v);
    endtask

    task automatic start_stream();
        armed = 1'b1;
    endtask

    task automatic finish_stream();
        if (armed && pos != exp_q.size() - 1) begin
            note_failure("playback ended before all expected output levels appeared");
        end
        armed = 1'b0;
    endtask

    // Each output level may hold for several ticks before the next one
    always @(negedge clk) begin
        if (armed && sample) begin
            if (int'(snd_left) != exp_q[pos] && pos + 1 < exp_q.size()
                && int'(snd_left) == exp_q[pos + 1]) begin
                pos++;
            end
            check_value("snd_right", exp_q[pos], int'(snd_right)); // Right copies left
            if (int'(snd_left) != exp_q[pos]) begin
                check_value("snd_left", exp_q[pos], int'(snd_left));
                armed = 1'b0;
            end
        end
    end

    task automatic end_test(input string name);
        tests++;
        if (test_errs == 0) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, test_errs);
            failed++;
        end
        test_errs = 0;
    endtask

    task automatic report();
        $display("%0d tests, %0d failed, %0d errors", tests, failed, err_count);
    endtask

endmodule

// File: verification/snd_board_tb.sv
// Sound board testbench
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_board_tb;

    logic                 clk;
    logic                 rst;
    snd_pkg::snd_bus_t    bus;
    logic                 snd_irq;
    snd_pkg::cpu_data_t   snd_latch;
    snd_pkg::cpu_data_t   rom_data;
    logic                 rom_ok;
    snd_pkg::cpu_data_t   fm_dout;
    snd_pkg::snd_sample_t fm_snd;
    snd_pkg::cpu_data_t   cpu_din;
    logic                 cpu_wait_n;
    logic                 rom_cs;
    logic [14:0]          rom_addr;
    logic                 ram_cs;
    logic                 fm_cs;
    logic                 int_n;
    logic                 pcm_cs;
    snd_pkg::pcm_addr_t   pcm_addr;
    snd_pkg::cpu_data_t   pcm_data = 8'd0;
    logic                 pcm_ok = 1'b0;
    snd_pkg::snd_sample_t snd_left;
    snd_pkg::snd_sample_t snd_right;
    logic                 sample;

    logic [7:0] pcm_mem [0:(1 << `PCM_AW) - 1];
    int         seed;
    int         lat_seed;
    int         lat_cnt;
    int         fetches;
    bit         lat_busy;
    bit         timed_out;
    int         step_tab [16] = '{1, 2, 3, 4, 6, 8, 11, 16, 22, 32, 45, 64, 90, 128, 181, 255};

    snd_board dut_i (.*);

    snd_board_checker chk_i (.clk, .sample, .snd_left, .snd_right);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Program ROM pattern over the whole address
    function automatic logic [7:0] rom_byte(input logic [14:0] a);
        rom_byte = a[7:0] ^ {1'b0, a[14:8]} ^ 8'h5a;
    endfunction

    assign rom_data = rom_byte(rom_addr);

    // Sample ROM answers after 1 to 8 cycles
    always @(negedge clk) begin
        if (rst || !pcm_cs) begin
            pcm_ok   = 1'b0;
            lat_busy = 1'b0;
        end else if (!lat_busy) begin
            lat_busy = 1'b1;
            lat_cnt  = 1 + ($unsigned($random(lat_seed)) % 8);
        end else if (!pcm_ok) begin
            lat_cnt = lat_cnt - 1;
            if (lat_cnt == 0) begin
                pcm_ok   = 1'b1;
                pcm_data = pcm_mem[pcm_addr];
                fetches  = fetches + 1;
            end
        end
    end

    function automatic int mix(input int fm, input int pcm);
        int v;
        v = (fm * `GAIN_FM + pcm * `GAIN_PCM) >>> 4;
        if (v > 32767) begin
            mix = 32767;
        end else if (v < -32768) begin
            mix = -32768;
        end else begin
            mix = v;
        end
    endfunction

    task automatic give_up(input string msg);
        if (!timed_out) begin
            chk_i.note_failure(msg);
        end
        timed_out = 1'b1;
    endtask

    task automatic write_bus(input logic [2:0] region, input logic [7:0] data);
        @(negedge clk);
        bus.addr  = {1'b1, region, 12'($random(seed))};
        bus.wdata = data;
        bus.mreq  = 1'b1;
        bus.rd    = 1'b0;
        bus.wr    = 1'b1;
        @(negedge clk);
        bus.wr   = 1'b0;
        bus.mreq = 1'b0;
    endtask

    task automatic read_bus(input logic [15:0] addr, output logic [7:0] data);
        @(negedge clk);
        bus.addr = addr;
        bus.mreq = 1'b1;
        bus.rd   = 1'b1;
        bus.wr   = 1'b0;
        #10;
        data = cpu_din;
    endtask

    task automatic wait_pulses(input int n);
        int seen;
        int cyc;
        seen = 0;
        cyc  = 0;
        while (seen < n && cyc < 200 * n && !timed_out) begin
            @(negedge clk);
            cyc++;
            if (sample) seen++;
        end
        if (seen < n) give_up("no sample pulse from the mixer");
    endtask

    // Polls the busy register until the player is free
    task automatic wait_idle();
        logic [7:0] d;
        int         cyc;
        d   = 8'd0;
        cyc = 0;
        while (!d[0] && cyc < 5000 && !timed_out) begin
            read_bus({1'b1, `MAP_BUSY, 12'h000}, d);
            cyc++;
        end
        bus.mreq = 1'b0;
        if (!d[0]) give_up("player stayed busy");
    endtask

    task automatic wait_int(input logic level);
        int cyc;
        cyc = 0;
        while (int_n !== level && cyc < 20 && !timed_out) begin
            @(negedge clk);
            cyc++;
        end
        if (int_n !== level) give_up("int_n did not change after irq edge or ack");
    endtask

    // Kind 0 is random bytes, 1 loud rising and 2 loud falling
    task automatic load_phrase(input int phrase, input int len, input int kind);
        int base;
        base = phrase * 512;
        pcm_mem[base] = 8'(len);
        for (int i = 1; i <= len; i++) begin
            pcm_mem[base + i] = (kind == 1) ? 8'h77 : (kind == 2) ? 8'hff : 8'($random(seed));
        end
    endtask

    // Reference ADPCM decode into deduplicated mixed levels
    task automatic build_stream(input int phrase, input int len, input int fm);
        int       s;
        int       idx;
        int       m;
        int       delta;
        int       v;
        int       last;
        logic [3:0] nib;
        s    = 0;
        idx  = 0;
        last = mix(fm, 0);
        chk_i.clear_stream();
        chk_i.push_expected(last);
        for (int b = 1; b <= len; b++) begin
            for (int h = 0; h < 2; h++) begin
                nib   = (h == 0) ? pcm_mem[phrase * 512 + b][7:4] : pcm_mem[phrase * 512 + b][3:0];
                m     = nib[2:0];
                delta = step_tab[idx] * (2 * m + 1) / 8;
                s     = nib[3] ? s - delta : s + delta;
                s     = (s > 255) ? 255 : (s < -255) ? -255 : s;
                idx   = (m < 4) ? ((idx > 0) ? idx - 1 : 0) : ((idx < 14) ? idx + 2 : 15);
                v     = mix(fm, s);
                if (v != last) chk_i.push_expected(v);
                last = v;
            end
        end
        if (mix(fm, 0) != last) chk_i.push_expected(mix(fm, 0));
    endtask

    task automatic play(input int phrase);
        write_bus(`MAP_PLATCH, 8'(phrase));
        write_bus(`MAP_PLAY, 8'h00); // Bit 1 clear starts
    endtask

    task automatic run_phrase(input string name, input int len, input int kind, input int fm);
        int         phrase;
        logic [7:0] d;
        phrase = $unsigned($random(seed)) % 256;
        fm_snd = 16'(fm);
        wait_pulses(2);
        load_phrase(phrase, len, kind);
        build_stream(phrase, len, fm);
        chk_i.start_stream();
        fetches = 0;
        play(phrase);
        read_bus({1'b1, `MAP_BUSY, 12'h000}, d);
        chk_i.check_value("busy bit 0 during playback", 0, d[0]);
        wait_idle();
        chk_i.check_value("sample ROM reads", len + 1, fetches); // Length byte and data
        wait_pulses(3);
        chk_i.finish_stream();
        chk_i.end_test(name);
    endtask

    initial begin
        logic [15:0] a;
        logic [7:0]  d;
        int          exp;
        seed      = 32'h592b_0021;
        lat_seed  = seed ^ 32'h0000_5a5a;
        timed_out = 1'b0;
        fetches   = 0;
        bus       = '0;
        snd_irq   = 1'b0;
        snd_latch = 8'd0;
        rom_ok    = 1'b1;
        fm_dout   = 8'd0;
        fm_snd    = '0;
        rst       = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 40; i++) begin
            a         = 16'($random(seed));
            snd_latch = 8'($random(seed));
            fm_dout   = 8'($random(seed));
            rom_ok    = 1'($random(seed));
            read_bus(a, d);
            if (!a[15]) begin
                exp = rom_byte(a[14:0]);
            end else if (a[14:12] == `MAP_LATCH) begin
                exp = snd_latch;
            end else if (a[14:12] == `MAP_FM) begin
                exp = fm_dout;
            end else if (a[14:12] == `MAP_BUSY) begin
                exp = 1;
            end else begin
                exp = 8'hff;
            end
            chk_i.check_value("cpu_din", exp, d);
            chk_i.check_value("rom_cs", !a[15], rom_cs);
            chk_i.check_value("ram_cs", a[15] && a[14:12] == `MAP_RAM, ram_cs);
            chk_i.check_value("fm_cs", a[15] && a[14:12] == `MAP_FM, fm_cs);
            chk_i.check_value("cpu_wait_n", rom_ok, cpu_wait_n);
        end
        bus.mreq = 1'b0;
        rom_ok   = 1'b1;
        chk_i.end_test("random reads");

        @(negedge clk);
        snd_irq = 1'b1;
        wait_int(1'b0);
        repeat (5) @(negedge clk);
        chk_i.check_value("int_n", 0, int_n);
        bus.irq_ack = 1'b1;
        @(negedge clk);
        bus.irq_ack = 1'b0;
        wait_int(1'b1);
        snd_irq = 1'b0;
        chk_i.end_test("interrupt");

        write_bus(`MAP_PRST, 8'h01); // Release the player
        for (int i = 0; i < 3; i++) begin
            run_phrase("phrase playback", 1 + ($unsigned($random(seed)) % 12), 0,
                       int'(16'sh0000 + 16'($random(seed))) % 4096);
        end

        fm_snd = 16'($random(seed));
        wait_pulses(2);
        load_phrase(17, 12, 0);
        play(17);
        wait_pulses(4);
        read_bus({1'b1, `MAP_BUSY, 12'h000}, d);
        chk_i.check_value("busy bit 0 before reset", 0, d[0]);
        write_bus(`MAP_PRST, 8'h00);
        read_bus({1'b1, `MAP_BUSY, 12'h000}, d);
        bus.mreq = 1'b0;
        chk_i.check_value("busy bit 0 under reset", 1, d[0]);
        wait_pulses(2);
        chk_i.check_value("snd_left", mix(fm_snd, 0), snd_left);
        chk_i.check_value("snd_right", mix(fm_snd, 0), snd_right);
        write_bus(`MAP_PRST, 8'h01);
        chk_i.end_test("player reset");

        run_phrase("saturation high", 4 + ($unsigned($random(seed)) % 9), 1, 32767);
        run_phrase("saturation low", 4 + ($unsigned($random(seed)) % 9), 2, -32767);

        chk_i.report();
        if (chk_i.err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
